//--- list.f
+incdir+.
char_rec_pkg.sv
frame_sequencer.sv
grid_config.sv
cell_locator.sv
cell_counter_bank.sv
character_recognition.sv
tb_clock_gen.sv
tb_character_recognition.sv

//--- Bender.yml
package:
  name: character_recognition

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - char_rec_pkg.sv
      - frame_sequencer.sv
      - grid_config.sv
      - cell_locator.sv
      - cell_counter_bank.sv
      - character_recognition.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_character_recognition.sv

//--- tb_character_recognition.sv
// character recognition testbench
`include "char_rec_settings.svh"

module tb_character_recognition;
   import char_rec_pkg::*;

   localparam int N_RANDOM = 5;
   // random trials, ink-on-edges trial, two frames of the skipped-eval trial
   localparam int N_SCANS  = N_RANDOM + 3;
   // largest box reaches 136 by 142, scanned two past the far edges
   localparam int SCAN_MAX = (136 + 3) * (142 + 3);
   localparam int TIMEOUT  = N_SCANS * (SCAN_MAX + 40) * 4 + 2000;
   localparam int IDLE_POS = 4095;
   localparam int CNT_MAX  = (1 << `CR_CNT_W) - 1;

   logic                   pixelclk;
   logic                   reset_n;
   logic [`CR_PHASE_W-1:0] i_frame_phase;
   logic [`CR_RGB_W-1:0]   i_rgb;
   logic                   i_vsync;
   logic [`CR_COORD_W-1:0] i_hcount;
   logic [`CR_COORD_W-1:0] i_vcount;
   logic [`CR_COORD_W-1:0] i_hcount_l;
   logic [`CR_COORD_W-1:0] i_hcount_r;
   logic [`CR_COORD_W-1:0] i_vcount_l;
   logic [`CR_COORD_W-1:0] i_vcount_r;
   char_pattern_u          o_char;
   logic                   o_char_valid;

   // --------------------
   // model state
   logic [31:0]            lfsr_q;
   int                     box_hr;
   int                     box_vr;
   int                     col_e [`CR_COLS+1];
   int                     row_e [`CR_ROWS+1];
   int                     thr;
   int                     model_cnt [`CR_CELLS];
   int                     cell_level [`CR_CELLS];
   int                     cycle_no;
   int                     valid_seen;
   int                     valid_cycle;
   int                     publishes;
   logic [`CR_CELLS-1:0]   seen_char;
   int                     value_errs;
   int                     other_errs;
   logic [`CR_PHASE_W-1:0] skip_ph;

   tb_clock_gen clock_gen_i (
      .pixelclk (pixelclk),
      .reset_n  (reset_n)
   );

   character_recognition character_recognition_i (
      .pixelclk      (pixelclk),
      .reset_n       (reset_n),
      .i_frame_phase (i_frame_phase),
      .i_rgb         (i_rgb),
      .i_vsync       (i_vsync),
      .i_hcount      (i_hcount),
      .i_vcount      (i_vcount),
      .i_hcount_l    (i_hcount_l),
      .i_hcount_r    (i_hcount_r),
      .i_vcount_l    (i_vcount_l),
      .i_vcount_r    (i_vcount_r),
      .o_char        (o_char),
      .o_char_valid  (o_char_valid)
   );

   // --------------------
   // random source, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // ink probability out of 16 per density level
   function automatic int dark_limit(input int level);
      case (level)
         0:       return 0;
         1:       return 5;
         2:       return 11;
         default: return 16;
      endcase
   endfunction

   // --------------------
   // grid model, equal parts with integer division
   function automatic int edge_pos(input int lo, input int hi, input int idx, input int div);
      return lo + ((hi - lo) * idx) / div;
   endfunction

   task automatic set_box(input int hl, input int hr, input int vl, input int vr);
      box_hr     = hr;
      box_vr     = vr;
      i_hcount_l = `CR_COORD_W'(hl);
      i_hcount_r = `CR_COORD_W'(hr);
      i_vcount_l = `CR_COORD_W'(vl);
      i_vcount_r = `CR_COORD_W'(vr);
      for (int c = 0; c <= `CR_COLS; c++) begin
         col_e[c] = edge_pos(hl, hr, c, `CR_COLS);
      end
      for (int r = 0; r <= `CR_ROWS; r++) begin
         row_e[r] = edge_pos(vl, vr, r, `CR_ROWS);
      end
      // half the area of cell (1,1), clipped to the counter
      thr = ((col_e[1] - col_e[0]) * (row_e[1] - row_e[0])) / 2;
      if (thr > CNT_MAX) begin
         thr = CNT_MAX;
      end
   endtask

   // box at least 10 by 16, well inside 0..255
   task automatic random_box();
      int hl;
      int vl;
      hl = rand_bits(6);
      vl = rand_bits(6);
      set_box(hl, hl + 10 + int'(rand_bits(6)), vl, vl + 16 + int'(rand_bits(6)));
   endtask

   // strictly inside a cell, else -1
   function automatic int locate(input int x, input int y);
      int col;
      int row;
      col = -1;
      row = -1;
      for (int c = 0; c < `CR_COLS; c++) begin
         if (x > col_e[c] && x < col_e[c+1]) col = c;
      end
      for (int r = 0; r < `CR_ROWS; r++) begin
         if (y > row_e[r] && y < row_e[r+1]) row = r;
      end
      if (col < 0 || row < 0) return -1;
      return row * `CR_COLS + col;
   endfunction

   // row-major, cell (1,1) in the msb
   function automatic logic [`CR_CELLS-1:0] model_pattern();
      logic [`CR_CELLS-1:0] p;
      for (int k = 0; k < `CR_CELLS; k++) begin
         p[`CR_CELLS-1-k] = (model_cnt[k] > thr);
      end
      return p;
   endfunction

   task automatic clear_model();
      for (int k = 0; k < `CR_CELLS; k++) begin
         model_cnt[k] = 0;
      end
   endtask

   // --------------------
   // one clock, outputs sampled just after the edge
   task automatic next_cycle();
      @(posedge pixelclk);
      #1;
      cycle_no++;
      if (o_char_valid === 1'b1) begin
         valid_seen++;
         valid_cycle = cycle_no;
         seen_char   = o_char.flat;
      end else if (o_char_valid !== 1'b0) begin
         other_errs++;
         $display("o_char_valid is unknown at cycle %0d", cycle_no);
      end
   endtask

   task automatic drive_idle();
      i_hcount = `CR_COORD_W'(IDLE_POS);
      i_vcount = `CR_COORD_W'(IDLE_POS);
      i_rgb    = `CR_WHITE;
   endtask

   // one-cycle vsync pulse, then the publish window
   task automatic vsync_edge(input logic [`CR_PHASE_W-1:0] ph);
      int                   edge_cycle;
      int                   valid_before;
      logic [`CR_CELLS-1:0] char_before;
      next_cycle();
      i_vsync       = 1'b1;
      i_frame_phase = ph;
      edge_cycle    = cycle_no;
      valid_before  = valid_seen;
      char_before   = o_char.flat;
      next_cycle();
      i_vsync = 1'b0;
      repeat (4) next_cycle();
      if (ph == `CR_PHASE_EVAL) begin
         publishes++;
         if (valid_seen - valid_before != 1) begin
            other_errs++;
            $display("o_char_valid pulsed %0d times after an eval edge, expected once",
                     valid_seen - valid_before);
         end else if (valid_cycle != edge_cycle + 2) begin
            other_errs++;
            $display("o_char_valid came %0d cycles after vsync was raised, expected 2",
                     valid_cycle - edge_cycle);
         end
      end else begin
         if (valid_seen != valid_before) begin
            other_errs++;
            $display("o_char_valid pulsed after a vsync edge in phase %0d", ph);
         end
         if (o_char.flat !== char_before) begin
            value_errs++;
            $display("[FAIL] o_char expected 0x%010h got 0x%010h", char_before, o_char.flat);
         end
      end
   endtask

   // full raster up to two past the box, ink only on edges in edges_only mode
   task automatic scan_frame(input bit counted, input bit edges_only);
      int                   idx;
      logic                 dark;
      logic [`CR_RGB_W-1:0] rgb;
      for (int k = 0; k < `CR_CELLS; k++) begin
         cell_level[k] = rand_bits(2);
      end
      for (int y = 0; y <= box_vr + 2; y++) begin
         for (int x = 0; x <= box_hr + 2; x++) begin
            idx = locate(x, y);
            if (edges_only) begin
               dark = (idx < 0);
            end else if (idx < 0) begin
               dark = (rand_bits(1) != 0);
            end else begin
               dark = (rand_bits(4) < dark_limit(cell_level[idx]));
            end
            rgb = `CR_WHITE;
            if (dark) begin
               rgb = `CR_RGB_W'(rand_bits(24));
               // pure white would not be ink
               if (rgb == `CR_WHITE) rgb[0] = 1'b0;
            end
            if (counted && dark && idx >= 0 && model_cnt[idx] < CNT_MAX) begin
               model_cnt[idx]++;
            end
            next_cycle();
            i_hcount = `CR_COORD_W'(x);
            i_vcount = `CR_COORD_W'(y);
            i_rgb    = rgb;
         end
      end
      next_cycle();
      drive_idle();
      repeat (3) next_cycle();
   endtask

   task automatic check_char(input logic [`CR_CELLS-1:0] expected);
      if (seen_char !== expected) begin
         value_errs++;
         $display("[FAIL] o_char expected 0x%010h got 0x%010h", expected, seen_char);
      end
   endtask

   // --------------------
   // main sequence
   initial begin
      lfsr_q        = 32'hd098;
      cycle_no      = 0;
      valid_seen    = 0;
      valid_cycle   = 0;
      publishes     = 0;
      seen_char     = '0;
      value_errs    = 0;
      other_errs    = 0;
      i_frame_phase = '0;
      i_vsync       = 1'b0;
      drive_idle();
      set_box(0, 10, 0, 16);
      clear_model();
      @(posedge reset_n);
      repeat (2) next_cycle();

      // reset state
      if (o_char.flat !== '0) begin
         value_errs++;
         $display("[FAIL] o_char expected 0x%010h got 0x%010h", 40'h0, o_char.flat);
      end
      if (valid_seen != 0) begin
         other_errs++;
         $display("o_char_valid pulsed before any evaluation edge");
      end

      // random images, model restarts from zero each time
      for (int t = 0; t < N_RANDOM; t++) begin
         random_box();
         clear_model();
         vsync_edge(`CR_PHASE_COUNT);
         scan_frame(1'b1, 1'b0);
         vsync_edge(`CR_PHASE_EVAL);
         check_char(model_pattern());
      end

      // ink only on cell edges and outside the box
      random_box();
      clear_model();
      vsync_edge(`CR_PHASE_COUNT);
      scan_frame(1'b1, 1'b1);
      vsync_edge(`CR_PHASE_EVAL);
      check_char('0);

      // skipped eval edge, then a frame that must not count
      random_box();
      clear_model();
      vsync_edge(`CR_PHASE_COUNT);
      scan_frame(1'b1, 1'b0);
      skip_ph = `CR_PHASE_W'(rand_bits(3));
      if (skip_ph == `CR_PHASE_COUNT || skip_ph == `CR_PHASE_EVAL) skip_ph = '0;
      vsync_edge(skip_ph);
      scan_frame(1'b0, 1'b0);
      vsync_edge(`CR_PHASE_EVAL);
      check_char(model_pattern());

      if (valid_seen != publishes) begin
         other_errs++;
         $display("saw %0d o_char_valid pulses for %0d evaluation edges", valid_seen, publishes);
      end
      $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // --------------------
   // watchdog, sized from the longest possible scans
   initial begin
      #(TIMEOUT);
      $display("watchdog expired after %0d time units, the run did not finish", TIMEOUT);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- tb_clock_gen.sv
// testbench clock and reset
module tb_clock_gen #(
   parameter int PERIOD       = 4,
   parameter int RESET_CYCLES = 3
) (
   output logic pixelclk,
   output logic reset_n
);

   // free running pixel clock
   initial begin
      pixelclk = 1'b0;
      forever #(PERIOD / 2) pixelclk = ~pixelclk;
   end

   // reset low for a few edges, released off the edge
   initial begin
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge pixelclk);
      #1;
      reset_n = 1'b1;
   end

endmodule

//--- character_recognition.sv
// single character recognition top
`include "char_rec_settings.svh"

module character_recognition (
   input  logic                         pixelclk,
   input  logic                         reset_n,
   input  logic [`CR_PHASE_W-1:0]       i_frame_phase,
   input  logic [`CR_RGB_W-1:0]         i_rgb,
   input  logic                         i_vsync,
   input  logic [`CR_COORD_W-1:0]       i_hcount,
   input  logic [`CR_COORD_W-1:0]       i_vcount,
   input  logic [`CR_COORD_W-1:0]       i_hcount_l,
   input  logic [`CR_COORD_W-1:0]       i_hcount_r,
   input  logic [`CR_COORD_W-1:0]       i_vcount_l,
   input  logic [`CR_COORD_W-1:0]       i_vcount_r,
   output char_rec_pkg::char_pattern_u  o_char,
   output logic                         o_char_valid
);

   // sequencer strobes
   logic                               frame_start;
   logic                               count_en;
   logic                               eval;
   logic                               publish;

   // grid geometry
   logic [`CR_COLS:0][`CR_COORD_W-1:0] col_edge;
   logic [`CR_ROWS:0][`CR_COORD_W-1:0] row_edge;
   logic [`CR_CNT_W-1:0]               threshold;

   // located pixel
   logic                               hit;
   logic                               dark;
   logic [$clog2(`CR_CELLS)-1:0]       cell_idx;

   frame_sequencer frame_sequencer_i (
      .pixelclk      (pixelclk),
      .reset_n       (reset_n),
      .i_vsync       (i_vsync),
      .i_frame_phase (i_frame_phase),
      .o_frame_start (frame_start),
      .o_count_en    (count_en),
      .o_eval        (eval),
      .o_publish     (publish)
   );

   grid_config grid_config_i (
      .pixelclk      (pixelclk),
      .reset_n       (reset_n),
      .i_frame_start (frame_start),
      .i_hcount_l    (i_hcount_l),
      .i_hcount_r    (i_hcount_r),
      .i_vcount_l    (i_vcount_l),
      .i_vcount_r    (i_vcount_r),
      .o_col_edge    (col_edge),
      .o_row_edge    (row_edge),
      .o_threshold   (threshold)
   );

   cell_locator cell_locator_i (
      .pixelclk   (pixelclk),
      .reset_n    (reset_n),
      .i_rgb      (i_rgb),
      .i_hcount   (i_hcount),
      .i_vcount   (i_vcount),
      .i_count_en (count_en),
      .i_col_edge (col_edge),
      .i_row_edge (row_edge),
      .o_hit      (hit),
      .o_dark     (dark),
      .o_cell_idx (cell_idx)
   );

   cell_counter_bank cell_counter_bank_i (
      .pixelclk     (pixelclk),
      .reset_n      (reset_n),
      .i_hit        (hit),
      .i_dark       (dark),
      .i_cell_idx   (cell_idx),
      .i_threshold  (threshold),
      .i_eval       (eval),
      .i_publish    (publish),
      .o_char       (o_char),
      .o_char_valid (o_char_valid)
   );

endmodule

//--- cell_counter_bank.sv
// dark pixel counters and pattern register
`include "char_rec_settings.svh"

module cell_counter_bank (
   input  logic                         pixelclk,
   input  logic                         reset_n,
   input  logic                         i_hit,
   input  logic                         i_dark,
   input  logic [$clog2(`CR_CELLS)-1:0] i_cell_idx,
   input  logic [`CR_CNT_W-1:0]         i_threshold,
   input  logic                         i_eval,
   input  logic                         i_publish,
   output char_rec_pkg::char_pattern_u  o_char,
   output logic                         o_char_valid
);
   import char_rec_pkg::*;

   // one counter per cell, row-major
   logic [`CR_CNT_W-1:0] cnt_q [`CR_CELLS];

   // compare bits taken at the eval strobe
   char_pattern_u        eval_q;

   // --------------------
   // counters
   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         for (int k = 0; k < `CR_CELLS; k++) begin
            cnt_q[k] <= '0;
         end
      end else if (i_publish) begin
         // fresh start for the next counting frame
         for (int k = 0; k < `CR_CELLS; k++) begin
            cnt_q[k] <= '0;
         end
      end else if (i_hit && i_dark && (cnt_q[i_cell_idx] != '1)) begin
         // saturate at all ones
         cnt_q[i_cell_idx] <= cnt_q[i_cell_idx] + 1'b1;
      end
   end

   // --------------------
   // threshold compare
   // cell (r,c) goes to row word ROWS-1-r, bit COLS-1-c
   always_ff @(posedge pixelclk) begin
      if (i_eval) begin
         for (int r = 0; r < `CR_ROWS; r++) begin
            for (int c = 0; c < `CR_COLS; c++) begin
               eval_q.rows[`CR_ROWS-1-r][`CR_COLS-1-c] <=
                  (cnt_q[r*`CR_COLS+c] > i_threshold);
            end
         end
      end
   end

   // --------------------
   // published pattern, valid for one cycle
   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         o_char       <= '0;
         o_char_valid <= 1'b0;
      end else begin
         o_char_valid <= i_publish;
         if (i_publish) begin
            o_char.flat <= eval_q.flat;
         end
      end
   end

endmodule

//--- cell_locator.sv
// pixel to grid cell locator
`include "char_rec_settings.svh"

module cell_locator (
   input  logic                               pixelclk,
   input  logic                               reset_n,
   input  logic [`CR_RGB_W-1:0]               i_rgb,
   input  logic [`CR_COORD_W-1:0]             i_hcount,
   input  logic [`CR_COORD_W-1:0]             i_vcount,
   input  logic                               i_count_en,
   input  logic [`CR_COLS:0][`CR_COORD_W-1:0] i_col_edge,
   input  logic [`CR_ROWS:0][`CR_COORD_W-1:0] i_row_edge,
   output logic                               o_hit,
   output logic                               o_dark,
   output logic [$clog2(`CR_CELLS)-1:0]       o_cell_idx
);

   localparam int COL_W = $clog2(`CR_COLS);
   localparam int ROW_W = $clog2(`CR_ROWS);
   localparam int IDX_W = $clog2(`CR_CELLS);

   logic [COL_W-1:0] col_sel;
   logic [ROW_W-1:0] row_sel;
   logic             col_found;
   logic             row_found;
   logic [IDX_W-1:0] idx_nxt;

   // --------------------
   // strict compare against neighbouring edges
   // a pixel on an edge or outside the box finds nothing
   always_comb begin
      col_sel   = '0;
      col_found = 1'b0;
      for (int c = 0; c < `CR_COLS; c++) begin
         if (i_hcount > i_col_edge[c] && i_hcount < i_col_edge[c+1]) begin
            col_sel   = COL_W'(c);
            col_found = 1'b1;
         end
      end
   end

   always_comb begin
      row_sel   = '0;
      row_found = 1'b0;
      for (int r = 0; r < `CR_ROWS; r++) begin
         if (i_vcount > i_row_edge[r] && i_vcount < i_row_edge[r+1]) begin
            row_sel   = ROW_W'(r);
            row_found = 1'b1;
         end
      end
   end

   // row-major cell index
   assign idx_nxt = IDX_W'(row_sel) * IDX_W'(`CR_COLS) + IDX_W'(col_sel);

   // --------------------
   // output stage, one cycle latency
   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         o_hit <= 1'b0;
      end else begin
         o_hit <= i_count_en & col_found & row_found;
      end
   end

   // qualified by o_hit downstream
   always_ff @(posedge pixelclk) begin
      // anything but pure white is ink
      o_dark     <= (i_rgb != `CR_WHITE);
      o_cell_idx <= idx_nxt;
   end

endmodule

//--- grid_config.sv
// character box grid configuration
`include "char_rec_settings.svh"

module grid_config (
   input  logic                               pixelclk,
   input  logic                               reset_n,
   input  logic                               i_frame_start,
   input  logic [`CR_COORD_W-1:0]             i_hcount_l,
   input  logic [`CR_COORD_W-1:0]             i_hcount_r,
   input  logic [`CR_COORD_W-1:0]             i_vcount_l,
   input  logic [`CR_COORD_W-1:0]             i_vcount_r,
   output logic [`CR_COLS:0][`CR_COORD_W-1:0] o_col_edge,
   output logic [`CR_ROWS:0][`CR_COORD_W-1:0] o_row_edge,
   output logic [`CR_CNT_W-1:0]               o_threshold
);
   import char_rec_pkg::*;

   // box held for the whole frame
   logic [`CR_COORD_W-1:0]             hl_q;
   logic [`CR_COORD_W-1:0]             hr_q;
   logic [`CR_COORD_W-1:0]             vl_q;
   logic [`CR_COORD_W-1:0]             vr_q;
   logic [`CR_COLS:0][`CR_COORD_W-1:0] col_nxt;
   logic [`CR_ROWS:0][`CR_COORD_W-1:0] row_nxt;
   logic [`CR_COORD_W-1:0]             cell_w;
   logic [`CR_COORD_W-1:0]             cell_h;
   logic [2*`CR_COORD_W-1:0]           area_half;
   logic [`CR_CNT_W-1:0]               thr_nxt;

   // --------------------
   // box capture
   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         hl_q <= '0;
         hr_q <= '0;
         vl_q <= '0;
         vr_q <= '0;
      end else if (i_frame_start) begin
         hl_q <= i_hcount_l;
         hr_q <= i_hcount_r;
         vl_q <= i_vcount_l;
         vr_q <= i_vcount_r;
      end
   end

   // --------------------
   // edges, idx 0 and idx div land on the box bounds
   always_comb begin
      for (int c = 0; c <= `CR_COLS; c++) begin
         col_nxt[c] = grid_edge(hl_q, hr_q, c, `CR_COLS);
      end
      for (int r = 0; r <= `CR_ROWS; r++) begin
         row_nxt[r] = grid_edge(vl_q, vr_q, r, `CR_ROWS);
      end
   end

   // half area of cell (1,1)
   assign cell_w    = col_nxt[1] - col_nxt[0];
   assign cell_h    = row_nxt[1] - row_nxt[0];
   assign area_half = ((2*`CR_COORD_W)'(cell_w) * (2*`CR_COORD_W)'(cell_h)) >> 1;

   // clip to counter range
   assign thr_nxt = (|area_half[2*`CR_COORD_W-1:`CR_CNT_W]) ? '1
                                                            : area_half[`CR_CNT_W-1:0];

   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         o_col_edge  <= '0;
         o_row_edge  <= '0;
         o_threshold <= '0;
      end else begin
         o_col_edge  <= col_nxt;
         o_row_edge  <= row_nxt;
         o_threshold <= thr_nxt;
      end
   end

endmodule

//--- frame_sequencer.sv
// frame phase sequencer
`include "char_rec_settings.svh"

module frame_sequencer (
   input  logic                   pixelclk,
   input  logic                   reset_n,
   input  logic                   i_vsync,
   input  logic [`CR_PHASE_W-1:0] i_frame_phase,
   output logic                   o_frame_start,
   output logic                   o_count_en,
   output logic                   o_eval,
   output logic                   o_publish
);

   logic vsync_q;
   logic vsync_rise;

   // --------------------
   // vsync edge detect
   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         vsync_q <= 1'b0;
      end else begin
         vsync_q <= i_vsync;
      end
   end

   // first high sample after a low one
   assign vsync_rise = i_vsync & ~vsync_q;

   // every frame start reloads the box
   assign o_frame_start = vsync_rise;

   // evaluation only at the start of an eval frame
   assign o_eval = vsync_rise && (i_frame_phase == `CR_PHASE_EVAL);

   // --------------------
   // count enable and publish strobe
   always_ff @(posedge pixelclk or negedge reset_n) begin
      if (!reset_n) begin
         o_count_en <= 1'b0;
         o_publish  <= 1'b0;
      end else begin
         // high through the whole counting frame
         o_count_en <= (i_frame_phase == `CR_PHASE_COUNT);
         // one cycle after the compare bits are taken
         o_publish  <= o_eval;
      end
   end

endmodule

//--- char_rec_pkg.sv
// character recognition types
`include "char_rec_settings.svh"

package char_rec_pkg;

   // --------------------
   // 40-bit pattern, flat word or 8 rows of 5
   // rows[ROWS-1] is row 1, col 1 sits in the row msb
   typedef union packed {
      logic [`CR_CELLS-1:0]               flat;
      logic [`CR_ROWS-1:0][`CR_COLS-1:0]  rows;
   } char_pattern_u;

   // --------------------
   // edge idx of div equal parts between lo and hi
   // span * idx / div + lo, integer division
   function automatic logic [`CR_COORD_W-1:0] grid_edge(
      input logic [`CR_COORD_W-1:0] lo,
      input logic [`CR_COORD_W-1:0] hi,
      input int unsigned            idx,
      input int unsigned            div
   );
      logic [`CR_COORD_W-1:0]   span;
      logic [2*`CR_COORD_W-1:0] prod;
      logic [2*`CR_COORD_W-1:0] quot;
      span = hi - lo;
      // wide product so idx * span never overflows
      prod = (2*`CR_COORD_W)'(span) * (2*`CR_COORD_W)'(idx);
      quot = prod / (2*`CR_COORD_W)'(div);
      return `CR_COORD_W'(quot) + lo;
   endfunction

endpackage

//--- char_rec_settings.svh
// character recognition settings
`ifndef CHAR_REC_SETTINGS_SVH
`define CHAR_REC_SETTINGS_SVH

// pixel coordinates and box edges
`define CR_COORD_W     12

// rgb pixel, white is all ones
`define CR_RGB_W       24
`define CR_WHITE       {`CR_RGB_W{1'b1}}

// grid size, row-major
`define CR_COLS        5
`define CR_ROWS        8
`define CR_CELLS       40

// per-cell dark pixel counter
`define CR_CNT_W       12

// frame phase codes
`define CR_PHASE_W     3
`define CR_PHASE_COUNT 3'd1
`define CR_PHASE_EVAL  3'd2

`endif
